// File: Makefile
VERILATOR ?= verilator
TOP       ?= usart_tb
FILELIST  ?= usart_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || { cat $(LOG); exit 1; }
	cat $(LOG)
	! grep -q '\*\* FAIL \*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/usart_tb.sv
/*
 * USART testbench
 * clock and reset, row table of mode, command, character and expected status,
 * CPU bus tasks, serial driver on rcd, txd monitor, checks and summary
 */
`default_nettype none
`include "usart_cfg.svh"

module usart_tb;

    typedef struct packed
    {
        logic [7:0] mode;
        logic [7:0] cmd;                          // no error or internal reset bits
        logic [7:0] ch;
        logic [1:0] inject;
        logic [7:0] exp_status;                   // status read after the receive
    } row_t;

    localparam int         NROWS       = 6;
    localparam logic [1:0] INJ_NONE    = 2'd0;
    localparam logic [1:0] INJ_PARITY  = 2'd1;    // inverted parity bit
    localparam logic [1:0] INJ_STOP    = 2'd2;    // stop bit sent low
    localparam logic [1:0] INJ_OVERRUN = 2'd3;    // second frame, no read between

    logic                    rxc_;
    logic                    transmitter_reset;
    logic                    chipsel_;
    logic                    comdat_;
    logic                    read_;
    logic                    write_;
    logic [`USART_BUS_W-1:0] wr_data;
    logic                    rcd;
    logic                    cts_;
    wire  [7:0]              rd_data;
    wire                     txd;
    wire                     rxrdy;
    wire                     txrdy;
    wire                     txe;
    wire                     rts_;
    wire                     dtr_;

    row_t   rows [NROWS];
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     limit  = 0;
    int     cur_row = -1;                         // -1 before the first row
    integer seed   = 32'h9dae;

    usart_top i_usart_top
    (
        .rxc_              (rxc_),
        .transmitter_reset (transmitter_reset),
        .chipsel_          (chipsel_),
        .comdat_           (comdat_),
        .read_             (read_),
        .write_            (write_),
        .wr_data           (wr_data),
        .rd_data           (rd_data),
        .rcd               (rcd),
        .cts_              (cts_),
        .txd               (txd),
        .rxrdy             (rxrdy),
        .txrdy             (txrdy),
        .txe               (txe),
        .rts_              (rts_),
        .dtr_              (dtr_)
    );

    initial
    begin
        rxc_ = 1'b0;
        forever #5 rxc_ = ~rxc_;                  // period 10
    end

    initial
    begin
        @(posedge rxc_);
        while (cycles < limit)
        begin
            @(posedge rxc_);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("** FAIL **");
        $finish;
    end

    function automatic int baud_f(input logic [1:0] b);
        case (b)
            2'b10:   return 16;
            2'b11:   return 64;
            default: return 1;                    // 1x and the sync code
        endcase
    endfunction

    function automatic int char_bits(input logic [7:0] mode);
        return 5 + int'(mode[3:2]);
    endfunction

    function automatic logic [7:0] char_mask(input logic [7:0] mode);
        return 8'((1 << char_bits(mode)) - 1);
    endfunction

    function automatic int stop_cycles(input logic [7:0] mode);
        int f;
        f = baud_f(mode[1:0]);
        case (mode[7:6])
            2'b10:   return f + f / 2;            // 1.5 stop bits
            2'b11:   return 2 * f;
            default: return f;
        endcase
    endfunction

    task automatic tick;
        @(posedge rxc_);
        #1;                                       // drive and sample after the edge
    endtask

    task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("MISMATCH row %0d %s: got %h expected %h", cur_row, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1)
        else
        begin
            $display("ERROR row %0d: %s", cur_row, what);
            errors++;
        end
    endtask

    task automatic bus_write(input logic c, input logic [7:0] d);
        chipsel_ = 1'b0;
        write_   = 1'b0;
        comdat_  = c;
        wr_data  = d;
        tick;                                     // strobe low for one cycle
        chipsel_ = 1'b1;
        write_   = 1'b1;
    endtask

    task automatic bus_read(input logic c, output logic [7:0] d);
        chipsel_ = 1'b0;
        read_    = 1'b0;
        comdat_  = c;
        tick;
        chipsel_ = 1'b1;
        read_    = 1'b1;
        d        = rd_data;                       // registered at the read edge
    endtask

    task automatic drive_frame(input logic [7:0] mode, input logic [7:0] ch,
                               input logic bad_par, input logic bad_stop);
        int         f;
        logic [7:0] data;
        f    = baud_f(mode[1:0]);
        data = ch & char_mask(mode);
        rcd  = 1'b0;                              // start bit
        repeat (f) tick;
        for (int b = 0; b < char_bits(mode); b++)
        begin
            rcd = data[b];                        // lsb first
            repeat (f) tick;
        end
        if (mode[4])
        begin
            rcd = ^data ^ ~mode[5] ^ bad_par;
            repeat (f) tick;
        end
        rcd = ~bad_stop;
        repeat (f) tick;
        rcd = 1'b1;
        repeat (2 * f) tick;                      // idle gap
    endtask

    task automatic watch_frame(input logic [7:0] mode, input logic [7:0] ch);
        int         f;
        int         wait_n;
        logic [7:0] data;
        f      = baud_f(mode[1:0]);
        data   = ch & char_mask(mode);
        wait_n = 0;
        while (txd !== 1'b0 && wait_n < 4)
        begin
            tick;
            wait_n++;
        end
        check_true(txd === 1'b0, "no start bit after cts_ went low");
        if (txd === 1'b0)
        begin
            repeat (f / 2) tick;                  // middle of the start bit
            check_val("txd start", 8'(txd), 8'h00);
            for (int b = 0; b < char_bits(mode); b++)
            begin
                repeat (f) tick;
                check_val("txd data", 8'(txd), 8'(data[b]));
            end
            if (mode[4])
            begin
                repeat (f) tick;
                check_val("txd parity", 8'(txd), {7'd0, ^data ^ ~mode[5]});
            end
            repeat (f - f / 2) tick;              // first cycle of the stop period
            for (int s = 0; s < stop_cycles(mode); s++)
            begin
                check_val("txd stop", 8'(txd), 8'h01);
                tick;
            end
            check_val("txe", 8'(txe), 8'h01);
        end
    endtask

    task automatic gated_wait(input int n);
        for (int k = 0; k < n; k++)
        begin
            tick;
            check_val("txd gated", 8'(txd), 8'h01);
            check_val("txrdy gated", 8'(txrdy), 8'h00);
        end
    endtask

    task automatic run_row(input int i);
        row_t       r;
        logic [7:0] got;
        logic [7:0] ch2;
        int         f;
        int         n;
        int         errs_before;
        r           = rows[i];
        cur_row     = i;
        errs_before = errors;
        f           = baud_f(r.mode[1:0]);
        cts_        = 1'b0;
        bus_write(1'b1, 8'h40);                   // internal reset, next write is a mode
        bus_write(1'b1, r.mode);
        bus_write(1'b1, r.cmd & 8'hfe);           // tx enable off at first
        check_val("dtr_", 8'(dtr_), {7'd0, ~r.cmd[1]});
        check_val("rts_", 8'(rts_), {7'd0, ~r.cmd[5]});
        bus_write(1'b0, r.ch);
        gated_wait(2 * f + 4);
        cts_ = 1'b1;
        bus_write(1'b1, r.cmd);
        gated_wait(2 * f + 4);
        cts_ = 1'b0;
        watch_frame(r.mode, r.ch);
        drive_frame(r.mode, r.ch, r.inject == INJ_PARITY, r.inject == INJ_STOP);
        ch2 = r.ch;
        if (r.inject == INJ_OVERRUN)
        begin
            ch2 = 8'($random(seed));
            drive_frame(r.mode, ch2, 1'b0, 1'b0);
        end
        n = 0;
        while (!rxrdy && n < 4 * f + 8)
        begin
            tick;
            n++;
        end
        check_true(rxrdy, "rxrdy did not rise after the received frame");
        bus_read(1'b1, got);
        check_val("status", got, r.exp_status);
        bus_read(1'b0, got);
        check_val("rd_data", got, ch2 & char_mask(r.mode));
        check_val("rxrdy", 8'(rxrdy), 8'h00);
        bus_write(1'b1, r.cmd | 8'h10);           // error reset
        tick;
        bus_read(1'b1, got);
        check_val("status cleared", got, 8'h05);  // txe and txrdy only
        $display("row %0d mode %h cmd %h: %0d errors", i, r.mode, r.cmd, errors - errs_before);
    endtask

    task automatic load_table;
        rows[0] = '{8'h4e, 8'h27, 8'ha5, INJ_NONE,    8'h07};  // 16x 8N1
        rows[1] = '{8'h79, 8'h05, 8'h5a, INJ_PARITY,  8'h0f};  // 1x 7E1
        rows[2] = '{8'hd3, 8'h07, 8'h3c, INJ_STOP,    8'h27};  // 64x 5O2
        rows[3] = '{8'hb6, 8'h25, 8'hc9, INJ_OVERRUN, 8'h17};  // 16x 6E1.5
        rows[4] = '{8'h5c, 8'h27, 8'h81, INJ_NONE,    8'h07};  // sync code as 1x, 8O1
        rows[5] = '{8'hc5, 8'h05, 8'h2d, INJ_STOP,    8'h27};  // 1x 6N2
    endtask

    initial
    begin
        transmitter_reset = 1'b1;
        chipsel_          = 1'b1;
        comdat_           = 1'b1;
        read_             = 1'b1;
        write_            = 1'b1;
        wr_data           = '0;
        rcd               = 1'b1;                 // line at mark
        cts_              = 1'b1;
        load_table();
        limit = 200;
        for (int i = 0; i < NROWS; i++)
            limit += 3 * 12 * baud_f(rows[i].mode[1:0]);
        repeat (4) @(posedge rxc_);
        #1;
        transmitter_reset = 1'b0;
        check_val("txd", 8'(txd), 8'h01);
        check_val("rts_", 8'(rts_), 8'h01);
        check_val("dtr_", 8'(dtr_), 8'h01);
        check_val("txrdy", 8'(txrdy), 8'h00);
        check_val("rxrdy", 8'(rxrdy), 8'h00);
        check_val("txe", 8'(txe), 8'h01);
        bus_write(1'b1, 8'h4e);                   // first mode after reset
        for (int i = 0; i < NROWS; i++)
            run_row(i);
        $display("%0d rows, %0d checks, %0d errors", NROWS, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/usart_cfg.svh
/*
 * USART build constants
 * CPU bus width, baud counter width and stop-length codes
 */
`ifndef USART_CFG_SVH
`define USART_CFG_SVH

`define USART_BUS_W       8       // CPU write and read buses
`define USART_BAUD_CNT_W  7       // holds up to 2 x 64 - 1

`define USART_STOP_1      2'b01   // one stop bit
`define USART_STOP_1P5    2'b10   // one and a half stop bits
`define USART_STOP_2      2'b11   // two stop bits

`endif

// File: rtl/usart_cpu_port.sv
/*
 * CPU side of the USART
 * access decode, mode then command sequencing,
 * transmit holding register and registered read data
 */
`default_nettype none
`include "usart_cfg.svh"

module usart_cpu_port
(
    input  wire                     rxc_,
    input  wire                     transmitter_reset,
    input  wire                     chipsel_,
    input  wire                     comdat_,
    input  wire                     read_,
    input  wire                     write_,
    input  wire [`USART_BUS_W-1:0]  wr_data,
    input  wire                     take,
    input  wire usart_pkg::status_t status_byte,
    input  wire [7:0]               rx_data,
    output logic [7:0]              rd_data,
    output logic [7:0]              hold_data,
    output logic                    hold_full,
    output logic                    data_read,
    usart_cfg_if.cpu                cfg
);
    import usart_pkg::*;

    logic     wr_strobe;                          // selected write cycle
    logic     rd_strobe;                          // selected read cycle
    logic     mode_done;                          // next control write is a command
    command_t cmd_in;

    assign wr_strobe = !chipsel_ && !write_;
    assign rd_strobe = !chipsel_ && !read_;
    assign cmd_in    = command_t'(wr_data);
    assign data_read = rd_strobe && !comdat_;     // pops the receive latch

    always_ff @(posedge rxc_)
    begin
        if (transmitter_reset)
        begin
            mode_done   <= 1'b0;
            cfg.mode    <= '0;
            cfg.command <= '0;                    // dtr_ rts_ high, tx rx off
            cfg.err_clr <= 1'b0;
            hold_full   <= 1'b0;
        end
        else
        begin
            cfg.err_clr <= 1'b0;
            if (wr_strobe && comdat_)
            begin
                if (!mode_done)
                begin
                    cfg.mode  <= mode_t'(wr_data);
                    mode_done <= 1'b1;
                end
                else if (cmd_in.internal_reset)
                begin
                    cfg.command <= '0;
                    mode_done   <= 1'b0;          // wait for a new mode
                end
                else
                begin
                    cfg.command             <= cmd_in;
                    cfg.command.error_reset <= 1'b0;  // bit is not kept
                    cfg.err_clr             <= cmd_in.error_reset;
                end
            end
            if (wr_strobe && !comdat_)
                hold_full <= 1'b1;                // overwrite allowed
            else if (take)
                hold_full <= 1'b0;
        end
    end

    always_ff @(posedge rxc_)
    begin
        if (wr_strobe && !comdat_)
            hold_data <= wr_data;
        if (rd_strobe)
            rd_data <= comdat_ ? status_byte : rx_data;  // held until next read
    end

    // one access at a time on the CPU bus
    a_rw_exclusive: assert property (@(posedge rxc_) disable iff (transmitter_reset)
        !chipsel_ |-> (read_ || write_));

endmodule

`default_nettype wire

// File: rtl/usart_if.sv
/*
 * USART internal interfaces
 * usart_cfg_if carries mode, command and the error clear
 * usart_rx_if carries one received character and its flags
 */
`default_nettype none

interface usart_cfg_if;
    import usart_pkg::*;

    mode_t    mode;                   // last mode instruction
    command_t command;                // last command, error reset masked off
    logic     err_clr;                // one-cycle clear of sticky errors

    modport cpu  (output mode, output command, output err_clr);
    modport tx   (input mode, input command);
    modport rx   (input mode);
    modport stat (input command, input err_clr);
endinterface

interface usart_rx_if;
    logic [7:0] rx_char;              // right aligned, upper bits zero
    logic       char_valid;           // single-cycle strobe
    logic       parity_err;           // valid with char_valid
    logic       frame_err;            // stop bit sampled low

    modport rx   (output rx_char, output char_valid, output parity_err, output frame_err);
    modport stat (input rx_char, input char_valid, input parity_err, input frame_err);
endinterface

`default_nettype wire

// File: rtl/usart_pkg.sv
/*
 * USART shared types
 * baud factor enum, mode and command bytes, status byte
 */
`default_nettype none

package usart_pkg;

    typedef enum logic [1:0]
    {
        BAUD_SYNC = 2'b00,            // sync code, run as 1x async here
        BAUD_1X   = 2'b01,
        BAUD_16X  = 2'b10,
        BAUD_64X  = 2'b11
    } baud_factor_e;

    typedef struct packed
    {
        logic [1:0]   stop_sel;       // stop length code
        logic         parity_even;    // 1 even, 0 odd
        logic         parity_en;
        logic [1:0]   char_len;       // 0..3 for 5..8 bits
        baud_factor_e baud;
    } mode_t;

    typedef struct packed
    {
        logic hunt;                   // sync only, ignored
        logic internal_reset;         // back to mode instruction
        logic rts_req;
        logic error_reset;            // clears PE OE FE
        logic send_break;             // not supported
        logic rx_enable;
        logic dtr_req;
        logic tx_enable;
    } command_t;

    typedef struct packed
    {
        logic dsr;                    // always 0
        logic syndet;                 // always 0
        logic frame_err;
        logic overrun_err;
        logic parity_err;
        logic txe;
        logic rxrdy;
        logic txrdy;
    } status_t;

endpackage

`default_nettype wire

// File: rtl/usart_receiver.sv
/*
 * USART receiver
 * rcd synchronizer, start qualification, mid-bit sampling,
 * parity and stop checks
 */
`default_nettype none
`include "usart_cfg.svh"

module usart_receiver
(
    input  wire        rxc_,
    input  wire        transmitter_reset,
    input  wire        rcd,
    usart_cfg_if.rx    cfg,
    usart_rx_if.rx     res
);
    import usart_pkg::*;

    typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

    rx_state_e                    state;
    logic                         rcd_meta;
    logic                         rcd_s;          // synchronized line
    logic [`USART_BAUD_CNT_W-1:0] f;
    logic [`USART_BAUD_CNT_W-1:0] f_m1;
    logic [`USART_BAUD_CNT_W-1:0] half_m1;        // wait to mid start bit
    logic [`USART_BAUD_CNT_W-1:0] baud_cnt;
    logic [2:0]                   bit_cnt;
    logic [2:0]                   last_bit;
    logic [7:0]                   shreg;
    logic                         valid;
    logic                         par_err;
    logic                         frm_err;
    logic                         bit_end;

    always_comb
    begin
        case (cfg.mode.baud)
            BAUD_16X: f = `USART_BAUD_CNT_W'(16);
            BAUD_64X: f = `USART_BAUD_CNT_W'(64);
            default:  f = `USART_BAUD_CNT_W'(1);
        endcase
        f_m1    = f - `USART_BAUD_CNT_W'(1);
        half_m1 = (f == `USART_BAUD_CNT_W'(1)) ? '0 : (f >> 1) - `USART_BAUD_CNT_W'(1);
    end

    assign last_bit       = 3'd4 + {1'b0, cfg.mode.char_len};
    assign bit_end        = (baud_cnt == '0);
    assign res.rx_char    = shreg;
    assign res.char_valid = valid;
    assign res.parity_err = par_err;
    assign res.frame_err  = frm_err;

    always_ff @(posedge rxc_)
    begin
        if (state == RX_IDLE)
            shreg <= '0;                          // upper bits stay zero
        else if (state == RX_DATA && bit_end)
            shreg[bit_cnt] <= rcd_s;
    end

    always_ff @(posedge rxc_)
    begin
        if (transmitter_reset)
        begin
            rcd_meta <= 1'b1;
            rcd_s    <= 1'b1;
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid    <= 1'b0;
            par_err  <= 1'b0;
            frm_err  <= 1'b0;
        end
        else
        begin
            rcd_meta <= rcd;
            rcd_s    <= rcd_meta;
            valid    <= 1'b0;
            if (state != RX_IDLE)
                baud_cnt <= baud_cnt - `USART_BAUD_CNT_W'(1);
            case (state)
                RX_IDLE:
                    if (!rcd_s)                   // candidate start bit
                    begin
                        par_err  <= 1'b0;
                        bit_cnt  <= '0;
                        baud_cnt <= half_m1;
                        // at 1x the low level itself is the check
                        state    <= (f == `USART_BAUD_CNT_W'(1)) ? RX_DATA : RX_START;
                    end
                RX_START:
                    if (bit_end)
                    begin
                        state    <= rcd_s ? RX_IDLE : RX_DATA;  // glitch rejected
                        baud_cnt <= f_m1;
                    end
                RX_DATA:
                    if (bit_end)
                    begin
                        baud_cnt <= f_m1;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == last_bit)
                            state <= cfg.mode.parity_en ? RX_PARITY : RX_STOP;
                    end
                RX_PARITY:
                    if (bit_end)
                    begin
                        baud_cnt <= f_m1;
                        par_err  <= ^shreg ^ rcd_s ^ !cfg.mode.parity_even;
                        state    <= RX_STOP;
                    end
                RX_STOP:
                    if (bit_end)
                    begin
                        valid   <= 1'b1;          // middle of first stop bit
                        frm_err <= !rcd_s;
                        state   <= RX_IDLE;
                    end
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    // each character is reported exactly once
    a_valid_pulse: assert property (@(posedge rxc_) disable iff (transmitter_reset)
        res.char_valid |=> !res.char_valid);

endmodule

`default_nettype wire

// File: rtl/usart_status.sv
/*
 * USART status
 * receive data latch, sticky PE OE FE, status byte,
 * ready and empty flags, modem control outputs
 */
`default_nettype none

module usart_status
(
    input  wire                      rxc_,
    input  wire                      transmitter_reset,
    input  wire                      cts_,
    input  wire                      hold_full,
    input  wire                      tx_busy,
    input  wire                      data_read,
    usart_cfg_if.stat                cfg,
    usart_rx_if.stat                 res,
    output usart_pkg::status_t       status_byte,
    output logic [7:0]               rx_data,
    output logic                     rxrdy,
    output logic                     txrdy,
    output logic                     txe,
    output logic                     rts_,
    output logic                     dtr_
);
    import usart_pkg::*;

    logic latch;                                  // take the new character
    logic pe;
    logic oe;
    logic fe;

    assign latch = res.char_valid && cfg.command.rx_enable;
    assign txrdy = !hold_full && cfg.command.tx_enable && !cts_;
    assign txe   = !hold_full && !tx_busy;
    assign rts_  = !cfg.command.rts_req;
    assign dtr_  = !cfg.command.dtr_req;

    always_ff @(posedge rxc_)
    begin
        if (latch)
            rx_data <= res.rx_char;               // newest character wins
    end

    always_ff @(posedge rxc_)
    begin
        if (transmitter_reset)
        begin
            rxrdy <= 1'b0;
            pe    <= 1'b0;
            oe    <= 1'b0;
            fe    <= 1'b0;
        end
        else
        begin
            if (latch)
                rxrdy <= 1'b1;
            else if (data_read)
                rxrdy <= 1'b0;
            if (cfg.err_clr)
            begin
                pe <= 1'b0;
                oe <= 1'b0;
                fe <= 1'b0;
            end
            else if (latch)
            begin
                pe <= pe | res.parity_err;
                fe <= fe | res.frame_err;
                oe <= oe | (rxrdy && !data_read);  // previous char never read
            end
        end
    end

    always_comb
    begin
        status_byte             = '0;             // dsr and syndet read zero
        status_byte.frame_err   = fe;
        status_byte.overrun_err = oe;
        status_byte.parity_err  = pe;
        status_byte.txe         = txe;
        status_byte.rxrdy       = rxrdy;
        status_byte.txrdy       = txrdy;
    end

endmodule

`default_nettype wire

// File: rtl/usart_top.sv
/*
 * USART top level
 * plain CPU and serial ports around the four blocks
 */
`default_nettype none
`include "usart_cfg.svh"

module usart_top
(
    input  wire                    rxc_,
    input  wire                    transmitter_reset,
    input  wire                    chipsel_,
    input  wire                    comdat_,
    input  wire                    read_,
    input  wire                    write_,
    input  wire [`USART_BUS_W-1:0] wr_data,
    output wire [7:0]              rd_data,
    input  wire                    rcd,
    input  wire                    cts_,
    output wire                    txd,
    output wire                    rxrdy,
    output wire                    txrdy,
    output wire                    txe,
    output wire                    rts_,
    output wire                    dtr_
);
    import usart_pkg::*;

    status_t    status_byte;
    logic [7:0] rx_data;                          // latched receive character
    logic [7:0] hold_data;                        // transmit holding register
    logic       hold_full;
    logic       take;
    logic       tx_busy;
    logic       data_read;

    usart_cfg_if cfg_if ();
    usart_rx_if  rx_if ();

    usart_cpu_port i_cpu_port
    (
        .rxc_              (rxc_),
        .transmitter_reset (transmitter_reset),
        .chipsel_          (chipsel_),
        .comdat_           (comdat_),
        .read_             (read_),
        .write_            (write_),
        .wr_data           (wr_data),
        .take              (take),
        .status_byte       (status_byte),
        .rx_data           (rx_data),
        .rd_data           (rd_data),
        .hold_data         (hold_data),
        .hold_full         (hold_full),
        .data_read         (data_read),
        .cfg               (cfg_if.cpu)
    );

    usart_transmitter i_transmitter
    (
        .rxc_              (rxc_),
        .transmitter_reset (transmitter_reset),
        .cts_              (cts_),
        .hold_data         (hold_data),
        .hold_full         (hold_full),
        .cfg               (cfg_if.tx),
        .take              (take),
        .txd               (txd),
        .tx_busy           (tx_busy)
    );

    usart_receiver i_receiver
    (
        .rxc_              (rxc_),
        .transmitter_reset (transmitter_reset),
        .rcd               (rcd),
        .cfg               (cfg_if.rx),
        .res               (rx_if.rx)
    );

    usart_status i_status
    (
        .rxc_              (rxc_),
        .transmitter_reset (transmitter_reset),
        .cts_              (cts_),
        .hold_full         (hold_full),
        .tx_busy           (tx_busy),
        .data_read         (data_read),
        .cfg               (cfg_if.stat),
        .res               (rx_if.stat),
        .status_byte       (status_byte),
        .rx_data           (rx_data),
        .rxrdy             (rxrdy),
        .txrdy             (txrdy),
        .txe               (txe),
        .rts_              (rts_),
        .dtr_              (dtr_)
    );

endmodule

`default_nettype wire

// File: rtl/usart_transmitter.sv
/*
 * USART transmitter
 * shift register, baud and bit counters, async frame on txd
 */
`default_nettype none
`include "usart_cfg.svh"

module usart_transmitter
(
    input  wire        rxc_,
    input  wire        transmitter_reset,
    input  wire        cts_,
    input  wire [7:0]  hold_data,
    input  wire        hold_full,
    usart_cfg_if.tx    cfg,
    output logic       take,
    output logic       txd,
    output logic       tx_busy
);
    import usart_pkg::*;

    typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;

    tx_state_e                    state;
    logic [`USART_BAUD_CNT_W-1:0] f;              // cycles per bit
    logic [`USART_BAUD_CNT_W-1:0] f_m1;
    logic [`USART_BAUD_CNT_W-1:0] stop_m1;        // stop period minus one
    logic [`USART_BAUD_CNT_W-1:0] baud_cnt;       // cycles left in this bit
    logic [2:0]                   bit_cnt;
    logic [2:0]                   last_bit;
    logic [7:0]                   mask;
    logic [7:0]                   shreg;
    logic                         par_bit;
    logic                         bit_end;
    logic                         stop_last;
    logic                         go;

    always_comb
    begin
        case (cfg.mode.baud)
            BAUD_16X: f = `USART_BAUD_CNT_W'(16);
            BAUD_64X: f = `USART_BAUD_CNT_W'(64);
            default:  f = `USART_BAUD_CNT_W'(1);  // 1x and the sync code
        endcase
        f_m1 = f - `USART_BAUD_CNT_W'(1);
        case (cfg.mode.stop_sel)
            `USART_STOP_1P5: stop_m1 = f_m1 + (f >> 1);
            `USART_STOP_2:   stop_m1 = f_m1 + f;
            default:         stop_m1 = f_m1;      // one stop, code 00 too
        endcase
    end

    assign mask      = 8'hff >> (2'd3 - cfg.mode.char_len);
    assign last_bit  = 3'd4 + {1'b0, cfg.mode.char_len};
    assign bit_end   = (baud_cnt == '0);
    assign stop_last = (state == TX_STOP) && bit_end;
    assign go        = hold_full && cfg.command.tx_enable && !cts_;
    assign take      = go && ((state == TX_IDLE) || stop_last);   // back to back frames
    assign tx_busy   = (state != TX_IDLE) && !stop_last;

    always_ff @(posedge rxc_)
    begin
        if (take)
        begin
            shreg   <= hold_data & mask;
            par_bit <= ^(hold_data & mask) ^ !cfg.mode.parity_even;
        end
        else if (bit_end && (state == TX_START || state == TX_DATA))
            shreg <= shreg >> 1;                  // next bit into shreg[0]
    end

    always_ff @(posedge rxc_)
    begin
        if (transmitter_reset)
        begin
            state    <= TX_IDLE;
            txd      <= 1'b1;                     // line idles at mark
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end
        else if (take)
        begin
            state    <= TX_START;
            txd      <= 1'b0;
            baud_cnt <= f_m1;
        end
        else
        begin
            if (state != TX_IDLE)
                baud_cnt <= baud_cnt - `USART_BAUD_CNT_W'(1);
            case (state)
                TX_START:
                    if (bit_end)
                    begin
                        state    <= TX_DATA;
                        txd      <= shreg[0];     // lsb first
                        baud_cnt <= f_m1;
                        bit_cnt  <= '0;
                    end
                TX_DATA:
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt != last_bit)
                        begin
                            txd      <= shreg[0];
                            baud_cnt <= f_m1;
                        end
                        else if (cfg.mode.parity_en)
                        begin
                            state    <= TX_PARITY;
                            txd      <= par_bit;
                            baud_cnt <= f_m1;
                        end
                        else
                        begin
                            state    <= TX_STOP;
                            txd      <= 1'b1;
                            baud_cnt <= stop_m1;
                        end
                    end
                TX_PARITY:
                    if (bit_end)
                    begin
                        state    <= TX_STOP;
                        txd      <= 1'b1;
                        baud_cnt <= stop_m1;
                    end
                TX_STOP:
                    if (bit_end)
                        state <= TX_IDLE;         // nothing held, go quiet
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    // between frames the line rests at mark, so a take never cuts a bit short
    a_idle_mark: assert property (@(posedge rxc_) disable iff (transmitter_reset)
        !tx_busy |-> txd);

endmodule

`default_nettype wire

// File: usart_top.f
+incdir+rtl
rtl/usart_pkg.sv
rtl/usart_if.sv
rtl/usart_cpu_port.sv
rtl/usart_transmitter.sv
rtl/usart_receiver.sv
rtl/usart_status.sv
rtl/usart_top.sv
dv/usart_tb.sv
